//--- l0_cache.sv
`timescale 1ns/1ns

module l0_cache import lsu_pkg::*; #(
  parameter int unsigned ALEN = 32,
  parameter int unsigned XLEN = 64,
  parameter int unsigned DEPTH = 8,
  localparam int unsigned IdxW = $clog2(DEPTH)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  // push from the store buffer
  input  logic            st_valid_i,
  input  logic [ALEN-1:0] st_addr_i,
  input  logic [IdxW-1:0] st_idx_i,
  // entry read back at the hint
  input  logic            st_cached_i,
  input  logic [ALEN-1:0] st_cached_addr_i,
  input  ldst_width_t     st_cached_width_i,
  input  logic [XLEN-1:0] st_cached_value_i,
  output logic [IdxW-1:0] st_idx_o,
  // held load
  input  logic [ALEN-1:0] ld_addr_i,
  input  ldst_width_t     ld_width_i,
  output logic            ld_valid_o,
  output logic [XLEN-1:0] ld_value_o
);

  // one slot per doubleword index
  logic [DEPTH-1:0] slot_valid_q;
  logic [IdxW-1:0]  slot_idx_q [DEPTH];

  logic [IdxW-1:0]  st_slot;
  logic [IdxW-1:0]  ld_slot;
  logic             st_cacheable;
  logic             ld_cacheable;
  logic             cache_upd;
  logic             st_hit;

  // --------------------
  // hint update
  // --------------------

  // i/o space never gets a hint
  assign st_cacheable = (st_addr_i & ALEN'(MMAP_MASK)) == '0;
  assign cache_upd    = st_valid_i & st_cacheable;
  // slot from the bits just above the byte offset
  assign st_slot      = st_addr_i[IdxW+2:3];

  // flush wins over a push in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= '0;
    end else if (flush_i) begin
      slot_valid_q <= '0;
    end else if (cache_upd) begin
      slot_valid_q[st_slot] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_upd && !flush_i) begin
      slot_idx_q[st_slot] <= st_idx_i;
    end
  end

  // --------------------
  // forwarding match
  // --------------------

  assign ld_slot      = ld_addr_i[IdxW+2:3];
  assign ld_cacheable = (ld_addr_i & ALEN'(MMAP_MASK)) == '0;
  assign st_idx_o     = slot_idx_q[ld_slot];

  // hinted entry still buffered, same address, same width
  assign st_hit = st_cached_i
                & (st_cached_addr_i == ld_addr_i)
                & (st_cached_width_i == ld_width_i);

  // a reused buffer slot could alias an i/o store, so gate on the load too
  assign ld_valid_o = slot_valid_q[ld_slot] & ld_cacheable & st_hit;
  assign ld_value_o = st_cached_value_i;

endmodule

//--- load_unit.sv
`timescale 1ns/1ns

module load_unit import lsu_pkg::*; #(
  parameter int unsigned ALEN = 32,
  parameter int unsigned XLEN = 64
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // load request
  input  logic            ld_req_i,
  input  logic [ALEN-1:0] ld_addr_i,
  input  ldst_width_t     ld_width_i,
  output logic            ld_busy_o,
  output logic            ld_done_o,
  output logic [XLEN-1:0] ld_data_o,
  output logic            ld_fwd_o,
  // held load to cache and buffer
  output logic [ALEN-1:0] lk_addr_o,
  output ldst_width_t     lk_width_o,
  input  logic            fwd_hit_i,
  input  logic [XLEN-1:0] fwd_value_i,
  input  logic            conflict_i,
  // memory read
  output logic            mem_re_o,
  output logic [ALEN-1:0] mem_raddr_o,
  output ldst_width_t     mem_rwidth_o,
  input  logic [XLEN-1:0] mem_rdata_i
);

  ld_state_t       state_q;
  ld_state_t       state_d;
  logic [ALEN-1:0] addr_q;
  ldst_width_t     width_q;
  logic [XLEN-1:0] data_q;
  logic            fwd_q;

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        if (ld_req_i) state_d = LD_LOOKUP;
      end
      LD_LOOKUP: begin
        // forward first, the hinted entry is the newest store there
        if (fwd_hit_i || !conflict_i) state_d = LD_DONE;
      end
      default: state_d = LD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LD_IDLE;
      fwd_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == LD_LOOKUP && fwd_hit_i) begin
        fwd_q <= 1'b1;
      end else if (state_q == LD_LOOKUP && !conflict_i) begin
        fwd_q <= 1'b0;
      end
    end
  end

  // request held for the whole lookup
  always_ff @(posedge clk_i) begin
    if (state_q == LD_IDLE && ld_req_i) begin
      addr_q  <= ld_addr_i;
      width_q <= ld_width_i;
    end
    if (state_q == LD_LOOKUP) begin
      if (fwd_hit_i) data_q <= fwd_value_i;
      else if (!conflict_i) data_q <= mem_rdata_i;
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign ld_busy_o    = (state_q != LD_IDLE);
  assign ld_done_o    = (state_q == LD_DONE);
  assign ld_data_o    = data_q;
  assign ld_fwd_o     = fwd_q;
  assign lk_addr_o    = addr_q;
  assign lk_width_o   = width_q;
  // read only once nothing buffered touches the doubleword
  assign mem_re_o     = (state_q == LD_LOOKUP) & ~fwd_hit_i & ~conflict_i;
  assign mem_raddr_o  = addr_q;
  assign mem_rwidth_o = width_q;

endmodule

//--- lsu_checker.sv
`timescale 1ns/1ns

module lsu_checker import lsu_pkg::*; #(
  parameter int unsigned DEPTH = 8,
  parameter int unsigned STUCK_LIMIT = 500
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // store side
  input  logic        st_req_i,
  input  logic [31:0] st_addr_i,
  input  ldst_width_t st_width_i,
  input  logic [63:0] st_value_i,
  input  logic        st_full_i,
  // load side
  input  logic        ld_req_i,
  input  logic        ld_busy_i,
  input  logic        ld_done_i,
  input  logic [63:0] ld_data_i,
  input  logic        ld_fwd_i,
  // memory ports
  input  logic        mem_we_i,
  input  logic [31:0] mem_waddr_i,
  input  ldst_width_t mem_wwidth_i,
  input  logic [63:0] mem_wdata_i,
  input  logic        mem_wstall_i,
  input  logic        mem_re_i,
  // expectation that travels with ld_req_i
  input  logic [63:0] exp_data_i,
  input  logic        exp_fwd_i,
  input  logic        fwd_check_i,
  input  logic        lat_check_i,
  output int          err_count_o,
  output int          check_count_o
);

  // stores accepted but not yet written, oldest first
  logic [31:0] q_addr  [$];
  ldst_width_t q_width [$];
  logic [63:0] q_data  [$];

  // the single load in flight
  logic        ld_pending;
  logic [63:0] ld_exp;
  logic        ld_fwd_exp;
  logic        ld_fwd_chk;
  logic        ld_lat_chk;
  int          ld_age;
  int          ld_reads;
  time         ld_time;

  initial begin
    err_count_o   = 0;
    check_count_o = 0;
    ld_pending    = 1'b0;
    ld_age        = 0;
    ld_reads      = 0;
  end

  // byte lanes of a width, built byte by byte
  function automatic logic [63:0] lane_mask(input ldst_width_t w);
    logic [63:0] m;
    m = '0;
    for (int b = 0; b < (1 << int'(w)); b++) begin
      m[8*b +: 8] = 8'hff;
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count_o++;
    if (got !== exp) begin
      err_count_o++;
      $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // control outputs right after reset release
  always @(posedge rst_ni) begin
    check_value("ld_done_o", ld_done_i, 0);
    check_value("ld_busy_o", ld_busy_i, 0);
    check_value("mem_we_o", mem_we_i, 0);
    check_value("mem_re_o", mem_re_i, 0);
    check_value("st_full_o", st_full_i, 0);
  end

  // --------------------
  // store buffer model
  // --------------------

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // occupancy alone decides full and the write level
      check_value("st_full_o", st_full_i, q_addr.size() == DEPTH);
      check_value("mem_we_o", mem_we_i, q_addr.size() != 0);
      // retire before push, same as an edge with both
      if (mem_we_i && !mem_wstall_i && q_addr.size() != 0) begin
        check_value("mem_waddr_o", mem_waddr_i, q_addr[0]);
        check_value("mem_wwidth_o", mem_wwidth_i, q_width[0]);
        check_value("mem_wdata_o", mem_wdata_i, q_data[0]);
        void'(q_addr.pop_front());
        void'(q_width.pop_front());
        void'(q_data.pop_front());
      end
      if (st_req_i && !st_full_i) begin
        q_addr.push_back(st_addr_i);
        q_width.push_back(st_width_i);
        q_data.push_back(st_value_i & lane_mask(st_width_i));
      end
    end
  end

  // --------------------
  // load responses
  // --------------------

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (ld_pending) ld_age++;
      // read strobes belong to the load in flight
      if (mem_re_i && !ld_pending) begin
        err_count_o++;
        $display("mem_re_o high at %0t with no load outstanding", $time);
      end
      if (ld_pending && mem_re_i) ld_reads++;
      if (ld_done_i) begin
        if (!ld_pending) begin
          err_count_o++;
          $display("ld_done_o pulsed at %0t with no load outstanding", $time);
        end else begin
          check_value("ld_data_o", ld_data_i, ld_exp);
          if (ld_fwd_chk) begin
            check_value("ld_fwd_o", ld_fwd_i, ld_fwd_exp);
            // one read strobe unless forwarded
            check_value("mem_re_o reads", ld_reads, ld_fwd_exp ? 0 : 1);
          end
          // two edges from request to the sampled done
          if (ld_lat_chk) check_value("ld_done_o latency", ld_age, 2);
          ld_pending = 1'b0;
        end
      end else if (ld_pending && ld_age == STUCK_LIMIT) begin
        err_count_o++;
        $display("load issued at %0t never completed", ld_time);
      end
      if (ld_req_i && !ld_busy_i) begin
        ld_pending = 1'b1;
        ld_age     = 0;
        ld_reads   = 0;
        ld_time    = $time;
        ld_exp     = exp_data_i;
        ld_fwd_exp = exp_fwd_i;
        ld_fwd_chk = fwd_check_i;
        ld_lat_chk = lat_check_i;
      end
    end
  end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

  // --------------------
  // access encodings
  // --------------------

  // access width, same two-bit code on every port
  typedef enum logic [1:0] {
    LS_BYTE   = 2'b00,
    LS_HALF   = 2'b01,
    LS_WORD   = 2'b10,
    LS_DOUBLE = 2'b11
  } ldst_width_t;

  // load unit states
  typedef enum logic [1:0] {
    LD_IDLE   = 2'b00,
    LD_LOOKUP = 2'b01,
    LD_DONE   = 2'b10
  } ld_state_t;

  // any of these bits set marks an i/o address, never cached
  localparam logic [31:0] MMAP_MASK = 32'h8000_0000;

  // byte lanes covered by a width, low aligned
  function automatic logic [63:0] width_mask(input ldst_width_t w);
    logic [63:0] m;
    case (w)
      LS_BYTE: m = 64'h0000_0000_0000_00ff;
      LS_HALF: m = 64'h0000_0000_0000_ffff;
      LS_WORD: m = 64'h0000_0000_ffff_ffff;
      default: m = 64'hffff_ffff_ffff_ffff;
    endcase
    return m;
  endfunction

endpackage

//--- lsu_top.sv
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned ALEN = 32,
  parameter int unsigned XLEN = 64,
  parameter int unsigned DEPTH = 8,
  localparam int unsigned IdxW = $clog2(DEPTH)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  // stores
  input  logic            st_req_i,
  input  logic [ALEN-1:0] st_addr_i,
  input  ldst_width_t     st_width_i,
  input  logic [XLEN-1:0] st_value_i,
  output logic            st_full_o,
  // loads
  input  logic            ld_req_i,
  input  logic [ALEN-1:0] ld_addr_i,
  input  ldst_width_t     ld_width_i,
  output logic            ld_busy_o,
  output logic            ld_done_o,
  output logic [XLEN-1:0] ld_data_o,
  output logic            ld_fwd_o,
  // memory write
  output logic            mem_we_o,
  output logic [ALEN-1:0] mem_waddr_o,
  output ldst_width_t     mem_wwidth_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic            mem_wstall_i,
  // memory read
  output logic            mem_re_o,
  output logic [ALEN-1:0] mem_raddr_o,
  output ldst_width_t     mem_rwidth_o,
  input  logic [XLEN-1:0] mem_rdata_i
);

  // --------------------
  // internal links
  // --------------------

  // buffer to cache
  logic            push;
  logic [ALEN-1:0] push_addr;
  logic [IdxW-1:0] push_idx;
  logic [IdxW-1:0] hint_idx;
  logic            cached;
  logic [ALEN-1:0] cached_addr;
  ldst_width_t     cached_width;
  logic [XLEN-1:0] cached_value;
  // load unit side
  logic [ALEN-1:0] lk_addr;
  ldst_width_t     lk_width;
  logic            fwd_hit;
  logic [XLEN-1:0] fwd_value;
  logic            ld_conflict;

  store_buffer #(
    .ALEN (ALEN),
    .XLEN (XLEN),
    .DEPTH(DEPTH)
  ) u_stbuf (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .st_req_i      (st_req_i),
    .st_addr_i     (st_addr_i),
    .st_width_i    (st_width_i),
    .st_value_i    (st_value_i),
    .st_full_o     (st_full_o),
    .push_o        (push),
    .push_addr_o   (push_addr),
    .push_idx_o    (push_idx),
    .hint_idx_i    (hint_idx),
    .cached_o      (cached),
    .cached_addr_o (cached_addr),
    .cached_width_o(cached_width),
    .cached_value_o(cached_value),
    .ld_addr_i     (lk_addr),
    .ld_conflict_o (ld_conflict),
    .mem_we_o      (mem_we_o),
    .mem_waddr_o   (mem_waddr_o),
    .mem_wwidth_o  (mem_wwidth_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_wstall_i  (mem_wstall_i)
  );

  l0_cache #(
    .ALEN (ALEN),
    .XLEN (XLEN),
    .DEPTH(DEPTH)
  ) u_l0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .st_valid_i       (push),
    .st_addr_i        (push_addr),
    .st_idx_i         (push_idx),
    .st_cached_i      (cached),
    .st_cached_addr_i (cached_addr),
    .st_cached_width_i(cached_width),
    .st_cached_value_i(cached_value),
    .st_idx_o         (hint_idx),
    .ld_addr_i        (lk_addr),
    .ld_width_i       (lk_width),
    .ld_valid_o       (fwd_hit),
    .ld_value_o       (fwd_value)
  );

  load_unit #(
    .ALEN(ALEN),
    .XLEN(XLEN)
  ) u_ld (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ld_req_i    (ld_req_i),
    .ld_addr_i   (ld_addr_i),
    .ld_width_i  (ld_width_i),
    .ld_busy_o   (ld_busy_o),
    .ld_done_o   (ld_done_o),
    .ld_data_o   (ld_data_o),
    .ld_fwd_o    (ld_fwd_o),
    .lk_addr_o   (lk_addr),
    .lk_width_o  (lk_width),
    .fwd_hit_i   (fwd_hit),
    .fwd_value_i (fwd_value),
    .conflict_i  (ld_conflict),
    .mem_re_o    (mem_re_o),
    .mem_raddr_o (mem_raddr_o),
    .mem_rwidth_o(mem_rwidth_o),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

//--- sources.f
lsu_pkg.sv
store_buffer.sv
l0_cache.sv
load_unit.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

//--- store_buffer.sv
`timescale 1ns/1ns

module store_buffer import lsu_pkg::*; #(
  parameter int unsigned ALEN = 32,
  parameter int unsigned XLEN = 64,
  parameter int unsigned DEPTH = 8,
  localparam int unsigned IdxW = $clog2(DEPTH)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // store request
  input  logic            st_req_i,
  input  logic [ALEN-1:0] st_addr_i,
  input  ldst_width_t     st_width_i,
  input  logic [XLEN-1:0] st_value_i,
  output logic            st_full_o,
  // push notice to the cache
  output logic            push_o,
  output logic [ALEN-1:0] push_addr_o,
  output logic [IdxW-1:0] push_idx_o,
  // entry selected by the cache hint
  input  logic [IdxW-1:0] hint_idx_i,
  output logic            cached_o,
  output logic [ALEN-1:0] cached_addr_o,
  output ldst_width_t     cached_width_o,
  output logic [XLEN-1:0] cached_value_o,
  // held load address
  input  logic [ALEN-1:0] ld_addr_i,
  output logic            ld_conflict_o,
  // drain to memory
  output logic            mem_we_o,
  output logic [ALEN-1:0] mem_waddr_o,
  output ldst_width_t     mem_wwidth_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic            mem_wstall_i
);

  // entry storage
  logic [DEPTH-1:0] valid_q;
  logic [ALEN-1:0]  addr_q  [DEPTH];
  ldst_width_t      width_q [DEPTH];
  logic [XLEN-1:0]  value_q [DEPTH];

  // ring pointers and occupancy
  logic [IdxW-1:0]  head_q;
  logic [IdxW-1:0]  tail_q;
  logic [IdxW:0]    count_q;

  logic             push;
  logic             pop;
  logic [DEPTH-1:0] dw_match;

  // --------------------
  // push and pop
  // --------------------

  assign st_full_o = (count_q == (IdxW+1)'(DEPTH));
  // full blocks a push even when the head retires this cycle
  assign push      = st_req_i & ~st_full_o;
  // oldest entry leaves on a write edge without stall
  assign pop       = mem_we_o & ~mem_wstall_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
    end else begin
      if (push) begin
        tail_q          <= tail_q + 1'b1;
        valid_q[tail_q] <= 1'b1;
      end
      // clearing valid kills any stale cache hint to this slot
      if (pop) begin
        head_q          <= head_q + 1'b1;
        valid_q[head_q] <= 1'b0;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload, value kept masked to its width
  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_q[tail_q]  <= st_addr_i;
      width_q[tail_q] <= st_width_i;
      value_q[tail_q] <= st_value_i & width_mask(st_width_i);
    end
  end

  // --------------------
  // cache side
  // --------------------

  assign push_o         = push;
  assign push_addr_o    = st_addr_i;
  assign push_idx_o     = tail_q;

  // entry behind the hint, valid bit says if it is still buffered
  assign cached_o       = valid_q[hint_idx_i];
  assign cached_addr_o  = addr_q[hint_idx_i];
  assign cached_width_o = width_q[hint_idx_i];
  assign cached_value_o = value_q[hint_idx_i];

  // doubleword compare against every live entry
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      dw_match[i] = valid_q[i] && (addr_q[i][ALEN-1:3] == ld_addr_i[ALEN-1:3]);
    end
  end

  assign ld_conflict_o = |dw_match;

  // --------------------
  // drain port
  // --------------------

  // head valid means the buffer is not empty
  assign mem_we_o     = valid_q[head_q];
  assign mem_waddr_o  = addr_q[head_q];
  assign mem_wwidth_o = width_q[head_q];
  assign mem_wdata_o  = value_q[head_q];

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu import lsu_pkg::*; ();

  localparam int unsigned DEPTH   = 8;
  // directed part plus the random mix
  localparam int unsigned N_OPS   = 340;
  localparam int unsigned TIMEOUT = 40 * N_OPS + 100;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        st_req;
  logic [31:0] st_addr;
  ldst_width_t st_width;
  logic [63:0] st_value;
  logic        st_full;
  logic        ld_req;
  logic [31:0] ld_addr;
  ldst_width_t ld_width;
  logic        ld_busy;
  logic        ld_done;
  logic [63:0] ld_data;
  logic        ld_fwd;
  logic        mem_we;
  logic [31:0] mem_waddr;
  ldst_width_t mem_wwidth;
  logic [63:0] mem_wdata;
  logic        mem_wstall;
  logic        mem_re;
  logic [31:0] mem_raddr;
  ldst_width_t mem_rwidth;
  logic [63:0] mem_rdata;
  // expectation for the checker
  logic [63:0] exp_data;
  logic        exp_fwd;
  logic        fwd_check;
  logic        lat_check;
  int          errors;
  int          checks;
  int          cycles;
  int          stall_mode;
  logic [31:0] seed;

  // memory model and program order view, i/o bit folded into the index
  logic [7:0]  mem    [512];
  logic [7:0]  shadow [512];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  lsu_top #(.ALEN(32), .XLEN(64), .DEPTH(DEPTH)) dut0 (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
    .st_req_i(st_req), .st_addr_i(st_addr), .st_width_i(st_width),
    .st_value_i(st_value), .st_full_o(st_full),
    .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_width_i(ld_width),
    .ld_busy_o(ld_busy), .ld_done_o(ld_done), .ld_data_o(ld_data), .ld_fwd_o(ld_fwd),
    .mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wwidth_o(mem_wwidth),
    .mem_wdata_o(mem_wdata), .mem_wstall_i(mem_wstall),
    .mem_re_o(mem_re), .mem_raddr_o(mem_raddr), .mem_rwidth_o(mem_rwidth),
    .mem_rdata_i(mem_rdata)
  );

  lsu_checker #(.DEPTH(DEPTH)) chk0 (
    .clk_i(clk), .rst_ni(rst_n),
    .st_req_i(st_req), .st_addr_i(st_addr), .st_width_i(st_width),
    .st_value_i(st_value), .st_full_i(st_full),
    .ld_req_i(ld_req), .ld_busy_i(ld_busy), .ld_done_i(ld_done),
    .ld_data_i(ld_data), .ld_fwd_i(ld_fwd),
    .mem_we_i(mem_we), .mem_waddr_i(mem_waddr), .mem_wwidth_i(mem_wwidth),
    .mem_wdata_i(mem_wdata), .mem_wstall_i(mem_wstall), .mem_re_i(mem_re),
    .exp_data_i(exp_data), .exp_fwd_i(exp_fwd), .fwd_check_i(fwd_check),
    .lat_check_i(lat_check), .err_count_o(errors), .check_count_o(checks)
  );

  function automatic int unsigned byte_idx(input logic [31:0] a);
    return {a[31], a[7:0]};
  endfunction

  // --------------------
  // memory model
  // --------------------

  always_comb begin
    mem_rdata = '0;
    // data only while the read strobe is up
    if (mem_re) begin
      for (int b = 0; b < (1 << int'(mem_rwidth)); b++) begin
        mem_rdata[8*b +: 8] = mem[byte_idx(mem_raddr + b)];
      end
    end
  end

  always @(posedge clk) begin
    if (mem_we && !mem_wstall) begin
      for (int b = 0; b < (1 << int'(mem_wwidth)); b++) begin
        mem[byte_idx(mem_waddr + b)] <= mem_wdata[8*b +: 8];
      end
    end
  end

  // zero extended bytes in program order
  function automatic logic [63:0] ref_load(input logic [31:0] a, input ldst_width_t w);
    logic [63:0] r;
    r = '0;
    for (int b = 0; b < (1 << int'(w)); b++) begin
      r[8*b +: 8] = shadow[byte_idx(a + b)];
    end
    return r;
  endfunction

  // --------------------
  // stimulus helpers
  // --------------------

  // 0 low, 1 high, 2 random
  task automatic drive_stall();
    case (stall_mode)
      0:       mem_wstall = 1'b0;
      1:       mem_wstall = 1'b1;
      default: mem_wstall = (($random(seed) & 3) == 0);
    endcase
  endtask

  task automatic set_stall(input int m);
    stall_mode = m;
    drive_stall();
  endtask

  // strobes last one cycle
  task automatic tick();
    @(posedge clk);
    #2;
    st_req = 1'b0;
    ld_req = 1'b0;
    flush  = 1'b0;
    drive_stall();
  endtask

  task automatic issue_store(input logic [31:0] a, input ldst_width_t w,
                             input logic [63:0] v);
    while (st_full) tick();
    st_req   = 1'b1;
    st_addr  = a;
    st_width = w;
    st_value = v;
    for (int b = 0; b < (1 << int'(w)); b++) begin
      shadow[byte_idx(a + b)] = v[8*b +: 8];
    end
    tick();
  endtask

  task automatic issue_load(input logic [31:0] a, input ldst_width_t w,
                            input logic fchk, input logic fexp, input logic lchk);
    while (ld_busy) tick();
    ld_req    = 1'b1;
    ld_addr   = a;
    ld_width  = w;
    exp_data  = ref_load(a, w);
    exp_fwd   = fexp;
    fwd_check = fchk;
    lat_check = lchk;
    tick();
  endtask

  task automatic wait_load();
    while (ld_busy) tick();
  endtask

  // load that must not forward, released after a few stalled cycles
  task automatic stalled_load(input logic [31:0] a, input ldst_width_t w);
    issue_load(a, w, 1'b1, 1'b0, 1'b0);
    repeat (4) tick();
    set_stall(0);
    wait_load();
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run still going after %0d cycles", TIMEOUT);
    $display("checks %0d, errors %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin
    logic [31:0] pick;
    logic [2:0]  off;
    logic [31:0] a;
    ldst_width_t w;
    seed  = 32'h8be4_9c83;
    rst_n = 1'b0;
    {flush, st_req, ld_req, mem_wstall} = '0;
    {st_addr, st_value, ld_addr, exp_data} = '0;
    {exp_fwd, fwd_check, lat_check} = '0;
    st_width   = LS_BYTE;
    ld_width   = LS_BYTE;
    stall_mode = 0;
    for (int i = 0; i < 512; i++) begin
      mem[i]    = i[7:0] ^ (i[8] ? 8'ha5 : 8'h3c);
      shadow[i] = mem[i];
    end
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    tick();

    // exact hit forwards in two cycles
    set_stall(1);
    issue_store(32'h10, LS_WORD, 64'h1122_3344_5566_7788);
    issue_load(32'h10, LS_WORD, 1'b1, 1'b1, 1'b1);
    wait_load();

    // width mismatch, i/o space, after a flush
    set_stall(1);
    issue_store(32'h20, LS_DOUBLE, {$random(seed), $random(seed)});
    stalled_load(32'h20, LS_HALF);
    set_stall(1);
    issue_store(32'h8000_0030, LS_WORD, {$random(seed), $random(seed)});
    stalled_load(32'h8000_0030, LS_WORD);
    set_stall(1);
    issue_store(32'h38, LS_BYTE, {$random(seed), $random(seed)});
    flush = 1'b1;
    tick();
    stalled_load(32'h38, LS_BYTE);

    // fill the buffer against a held stall
    while (mem_we) tick();
    set_stall(1);
    for (int i = 0; i < DEPTH; i++) begin
      issue_store(32'h40 + 8 * i, LS_DOUBLE, {$random(seed), $random(seed)});
    end
    repeat (2) tick();
    set_stall(0);
    repeat (2) tick();

    // random mix in a small window
    set_stall(2);
    for (int n = 0; n < 300; n++) begin
      pick = $random(seed);
      w    = ldst_width_t'(pick[1:0]);
      off  = pick[4:2] & (3'b111 << pick[1:0]);
      a    = {(pick[13:12] == 2'b00), 24'b0, pick[9:6], off};
      if (pick[20:17] == 4'b0000) begin
        flush = 1'b1;
        tick();
      end
      if (pick[16]) begin
        issue_store(a, w, {$random(seed), $random(seed)});
      end else begin
        issue_load(a, w, 1'b0, 1'b0, 1'b0);
        wait_load();
      end
    end

    // let every store reach memory
    set_stall(0);
    while (mem_we) tick();
    tick();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
